//--- source/median_pkg.sv
`default_nettype none

package median_pkg;

  localparam int PIX_W = 8;

  typedef struct packed {
    logic             valid;
    logic             sof;
    logic [PIX_W-1:0] pix;
  } pixel_beat_t;

  typedef struct packed {
    logic             valid;
    logic             sof;
    logic             sol;     // first column of a row.
    logic [PIX_W-1:0] top;     // row r-2.
    logic [PIX_W-1:0] mid;     // row r-1.
    logic [PIX_W-1:0] bot;     // row r, the newest pixel.
  } col_t;

  // p0..p8 in raster order, p4 is the centre pixel.
  typedef struct packed {
    logic             valid;
    logic [PIX_W-1:0] p0, p1, p2;
    logic [PIX_W-1:0] p3, p4, p5;
    logic [PIX_W-1:0] p6, p7, p8;
  } window_t;

  typedef struct packed {
    logic             valid;
    logic [PIX_W-1:0] median;
  } result_t;

  typedef enum logic [1:0] {
    ROW_FIRST,
    ROW_SECOND,
    ROWS_READY
  } row_phase_e;

endpackage

`default_nettype wire

//--- source/sort3.sv
`default_nettype none

module sort3 import median_pkg::*; (
  input  wire logic [PIX_W-1:0] a_i,
  input  wire logic [PIX_W-1:0] b_i,
  input  wire logic [PIX_W-1:0] c_i,
  output logic      [PIX_W-1:0] min_o,
  output logic      [PIX_W-1:0] med_o,
  output logic      [PIX_W-1:0] max_o
);

  logic             swap_ab;
  logic             swap_hc;
  logic             swap_lm;
  logic [PIX_W-1:0] lo_ab;
  logic [PIX_W-1:0] hi_ab;
  logic [PIX_W-1:0] lo_hc;

  // first comparator orders a and b.
  assign swap_ab = a_i > b_i;
  assign lo_ab   = swap_ab ? b_i : a_i;
  assign hi_ab   = swap_ab ? a_i : b_i;

  // the larger of a and b meets c, the winner is the maximum.
  assign swap_hc = hi_ab > c_i;
  assign max_o   = swap_hc ? hi_ab : c_i;
  assign lo_hc   = swap_hc ? c_i : hi_ab;

  // the two remaining values split into minimum and median.
  assign swap_lm = lo_ab > lo_hc;
  assign min_o   = swap_lm ? lo_hc : lo_ab;
  assign med_o   = swap_lm ? lo_ab : lo_hc;

endmodule

`default_nettype wire

//--- source/median_calc.sv
`default_nettype none

module median_calc import median_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire window_t win_i,
  output result_t      res_o
);

  function automatic logic [PIX_W-1:0] pix_max(input logic [PIX_W-1:0] a,
                                               input logic [PIX_W-1:0] b);
    return (a > b) ? a : b;
  endfunction

  function automatic logic [PIX_W-1:0] pix_min(input logic [PIX_W-1:0] a,
                                               input logic [PIX_W-1:0] b);
    return (a < b) ? a : b;
  endfunction

  window_t          s1_win;
  logic [PIX_W-1:0] row_min [3];
  logic [PIX_W-1:0] row_med [3];
  logic [PIX_W-1:0] row_max [3];
  logic [PIX_W-1:0] s2_min  [3];
  logic [PIX_W-1:0] s2_med  [3];
  logic [PIX_W-1:0] s2_max  [3];
  logic             s2_valid;
  logic [PIX_W-1:0] med_of_meds;
  logic [PIX_W-1:0] s3_lo;
  logic [PIX_W-1:0] s3_mid;
  logic [PIX_W-1:0] s3_hi;
  logic             s3_valid;
  logic [PIX_W-1:0] median;

  always_ff @(posedge clk) begin
    s1_win <= win_i;
    if (rst) begin
      s1_win.valid <= 1'b0;
    end
  end

  sort3 u_sort_row0 (
    .a_i(s1_win.p0), .b_i(s1_win.p1), .c_i(s1_win.p2),
    .min_o(row_min[0]), .med_o(row_med[0]), .max_o(row_max[0])
  );

  sort3 u_sort_row1 (
    .a_i(s1_win.p3), .b_i(s1_win.p4), .c_i(s1_win.p5),
    .min_o(row_min[1]), .med_o(row_med[1]), .max_o(row_max[1])
  );

  sort3 u_sort_row2 (
    .a_i(s1_win.p6), .b_i(s1_win.p7), .c_i(s1_win.p8),
    .min_o(row_min[2]), .med_o(row_med[2]), .max_o(row_max[2])
  );

  always_ff @(posedge clk) begin
    s2_min   <= row_min;
    s2_med   <= row_med;
    s2_max   <= row_max;
    s2_valid <= rst ? 1'b0 : s1_win.valid;
  end

  // only the median of the row medians needs a full sorter.
  sort3 u_sort_meds (
    .a_i(s2_med[0]), .b_i(s2_med[1]), .c_i(s2_med[2]),
    .min_o(), .med_o(med_of_meds), .max_o()
  );

  always_ff @(posedge clk) begin
    s3_lo    <= pix_max(pix_max(s2_min[0], s2_min[1]), s2_min[2]);
    s3_mid   <= med_of_meds;
    s3_hi    <= pix_min(pix_min(s2_max[0], s2_max[1]), s2_max[2]);
    s3_valid <= rst ? 1'b0 : s2_valid;
  end

  // the three candidates are not ordered, so a last sorter picks the median.
  sort3 u_sort_final (
    .a_i(s3_lo), .b_i(s3_mid), .c_i(s3_hi),
    .min_o(), .med_o(median), .max_o()
  );

  assign res_o = '{valid: s3_valid, median: median};

endmodule

`default_nettype wire

//--- source/line_buffer.sv
`default_nettype none

module line_buffer import median_pkg::*; #(
  parameter int IMG_WIDTH = 16
) (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire pixel_beat_t pix_i,
  output col_t             col_o
);

  localparam int               CNT_W    = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
  localparam logic [CNT_W-1:0] LAST_COL = CNT_W'(IMG_WIDTH - 1);

  logic [PIX_W-1:0] row1_mem [IMG_WIDTH];   // row r-1.
  logic [PIX_W-1:0] row2_mem [IMG_WIDTH];   // row r-2.
  logic [CNT_W-1:0] col_cnt;
  logic [CNT_W-1:0] wr_col;

  // a start of frame forces column zero in the same beat.
  assign wr_col = pix_i.sof ? '0 : col_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      col_cnt <= '0;
    end else if (pix_i.valid) begin
      col_cnt <= (wr_col == LAST_COL) ? '0 : wr_col + 1'b1;
    end
  end

  // rows move down one memory per visit of a column.
  always_ff @(posedge clk) begin
    if (pix_i.valid) begin
      row2_mem[wr_col] <= row1_mem[wr_col];
      row1_mem[wr_col] <= pix_i.pix;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      col_o.valid <= 1'b0;
    end else begin
      col_o.valid <= pix_i.valid;
    end
    if (pix_i.valid) begin
      col_o.sof <= pix_i.sof;
      col_o.sol <= (wr_col == '0);
      col_o.top <= row2_mem[wr_col];   // read before the write above lands.
      col_o.mid <= row1_mem[wr_col];
      col_o.bot <= pix_i.pix;
    end
  end

endmodule

`default_nettype wire

//--- source/window_gen.sv
`default_nettype none

module window_gen import median_pkg::*; #(
  parameter int IMG_WIDTH = 16
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire col_t col_i,
  output window_t   win_o
);

  localparam int                FILL_W   = $clog2(IMG_WIDTH + 1);
  localparam logic [FILL_W-1:0] FILL_ONE = FILL_W'(1);
  localparam logic [FILL_W-1:0] FILL_WIN = FILL_W'(3);
  localparam logic [FILL_W-1:0] FILL_MAX = FILL_W'(IMG_WIDTH);

  row_phase_e        row_phase;
  row_phase_e        phase_nxt;
  logic [FILL_W-1:0] fill;       // columns of the current row seen so far.
  logic [FILL_W-1:0] fill_nxt;
  logic              win_valid;
  logic [PIX_W-1:0]  top_q [3];  // index 2 holds the newest column.
  logic [PIX_W-1:0]  mid_q [3];
  logic [PIX_W-1:0]  bot_q [3];

  always_comb begin
    phase_nxt = row_phase;
    fill_nxt  = fill;
    if (col_i.sof) begin
      phase_nxt = ROW_FIRST;
      fill_nxt  = FILL_ONE;
    end else if (col_i.sol) begin
      case (row_phase)
        ROW_FIRST:  phase_nxt = ROW_SECOND;
        default:    phase_nxt = ROWS_READY;
      endcase
      fill_nxt = FILL_ONE;
    end else if (fill != FILL_MAX) begin
      fill_nxt = fill + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      row_phase <= ROW_FIRST;
      fill      <= '0;
      win_valid <= 1'b0;
    end else begin
      win_valid <= col_i.valid && (phase_nxt == ROWS_READY) && (fill_nxt >= FILL_WIN);
      if (col_i.valid) begin
        row_phase <= phase_nxt;
        fill      <= fill_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (col_i.valid) begin
      top_q <= '{top_q[1], top_q[2], col_i.top};
      mid_q <= '{mid_q[1], mid_q[2], col_i.mid};
      bot_q <= '{bot_q[1], bot_q[2], col_i.bot};
    end
  end

  assign win_o = '{valid: win_valid,
                   p0: top_q[0], p1: top_q[1], p2: top_q[2],
                   p3: mid_q[0], p4: mid_q[1], p5: mid_q[2],
                   p6: bot_q[0], p7: bot_q[1], p8: bot_q[2]};

endmodule

`default_nettype wire

//--- source/median_filter_top.sv
`default_nettype none

module median_filter_top import median_pkg::*; #(
  parameter int IMG_WIDTH = 16
) (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire pixel_beat_t pix_i,
  output result_t          res_o
);

  col_t    col;
  window_t win;

  line_buffer #(
    .IMG_WIDTH(IMG_WIDTH)
  ) u_line_buffer (
    .clk  (clk),
    .rst  (rst),
    .pix_i(pix_i),
    .col_o(col)
  );

  window_gen #(
    .IMG_WIDTH(IMG_WIDTH)
  ) u_window_gen (
    .clk  (clk),
    .rst  (rst),
    .col_i(col),
    .win_o(win)
  );

  // results come out five cycles after the pixel that closes a window.
  median_calc u_median_calc (
    .clk  (clk),
    .rst  (rst),
    .win_i(win),
    .res_o(res_o)
  );

endmodule

`default_nettype wire

//--- verification/median_filter_assertions.sv
`default_nettype none

module median_filter_assertions import median_pkg::*; (
  input wire logic        clk,
  input wire logic        rst,
  input wire pixel_beat_t pix_i,
  input wire result_t     res_i,
  input wire row_phase_e  row_phase_i
);

  timeunit 1ns;
  timeprecision 1ps;

  reset_quiet: assert property (@(posedge clk) $past(rst) |-> !res_i.valid)
    else $error("result valid while reset is applied");

  reset_phase: assert property (@(posedge clk) $past(rst) |-> row_phase_i == ROW_FIRST)
    else $error("row phase not cleared by reset");

  // line buffer, window, and three median stages give five cycles.
  fixed_latency: assert property (@(posedge clk) disable iff (rst)
    res_i.valid |-> $past(pix_i.valid, 5))
    else $error("result without an accepted pixel five cycles earlier");

  valid_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(res_i.valid))
    else $error("result valid is unknown");

  median_known: assert property (@(posedge clk) disable iff (rst)
    res_i.valid |-> !$isunknown(res_i.median))
    else $error("valid result carries an unknown median");

endmodule

bind median_filter_top median_filter_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .pix_i      (pix_i),
  .res_i      (res_o),
  .row_phase_i(u_window_gen.row_phase)
);

`default_nettype wire

//--- verification/median_filter_tb.sv
`default_nettype none

module median_filter_tb import median_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WIDTH       = 8;
  localparam int ROWS        = 6;
  localparam int PER_FRAME   = (ROWS - 2) * (WIDTH - 2);
  localparam int DRAIN_LIMIT = 200;

  logic        clk = 1'b0;
  logic        rst;
  pixel_beat_t pix;
  result_t     res;

  integer           seed;
  int               mismatches;
  int               other_errors;
  int               res_count;
  int               run_start;
  logic [PIX_W-1:0] exp_val;
  logic [PIX_W-1:0] frame [ROWS][WIDTH];
  logic [PIX_W-1:0] exp_q [$];
  logic [PIX_W-1:0] got_q [$];
  logic [PIX_W-1:0] base_q [$];

  median_filter_top #(
    .IMG_WIDTH(WIDTH)
  ) UUT (
    .clk  (clk),
    .rst  (rst),
    .pix_i(pix),
    .res_o(res)
  );

  always #50 clk = ~clk;

  function automatic logic [PIX_W-1:0] ref_median(input logic [PIX_W-1:0] vals [9]);
    logic [PIX_W-1:0] v [9];
    logic [PIX_W-1:0] t;
    v = vals;
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8 - i; j++) begin
        if (v[j] > v[j + 1]) begin
          t = v[j];
          v[j] = v[j + 1];
          v[j + 1] = t;
        end
      end
    end
    return v[4];
  endfunction

  // expected medians of all interior windows, in raster order.
  task automatic push_expected();
    logic [PIX_W-1:0] nb [9];
    for (int r = 1; r < ROWS - 1; r++) begin
      for (int c = 1; c < WIDTH - 1; c++) begin
        for (int k = 0; k < 9; k++) begin
          nb[k] = frame[r - 1 + k / 3][c - 1 + k % 3];
        end
        exp_q.push_back(ref_median(nb));
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < WIDTH; c++) begin
        frame[r][c] = PIX_W'($random(seed));
      end
    end
  endtask

  task automatic fill_constant(input logic [PIX_W-1:0] value);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < WIDTH; c++) begin
        frame[r][c] = value;
      end
    end
  endtask

  task automatic fill_checkerboard();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < WIDTH; c++) begin
        frame[r][c] = ((r + c) % 2 == 1) ? 8'd255 : 8'd0;
      end
    end
  endtask

  // called on a falling edge, returns on the falling edge after the last beat.
  task automatic send_frame(input bit gaps);
    int rnd;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < WIDTH; c++) begin
        rnd = $random(seed);
        while (gaps && (rnd & 3) == 0) begin  // about one idle cycle in four.
          pix.valid = 1'b0;
          @(negedge clk);
          rnd = $random(seed);
        end
        pix = '{valid: 1'b1, sof: (r == 0) && (c == 0), pix: frame[r][c]};
        @(negedge clk);
      end
    end
    pix = '0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("timeout: %0d expected results never arrived", exp_q.size());
    end
    repeat (8) @(negedge clk);  // room for a surplus result to show up.
  endtask

  task automatic check_count(input int expected);
    assert (res_count - run_start == expected) else begin
      other_errors++;
      $display("got %0d results instead of %0d", res_count - run_start, expected);
    end
  endtask

  task automatic run_frame(input bit gaps);
    run_start = res_count;
    got_q.delete();
    push_expected();
    send_frame(gaps);
    wait_drain();
    check_count(PER_FRAME);
  endtask

  task automatic compare_runs();
    assert (got_q.size() == base_q.size()) else begin
      other_errors++;
      $display("run with gaps gave %0d results, run without gaps %0d",
               got_q.size(), base_q.size());
    end
    for (int i = 0; i < got_q.size() && i < base_q.size(); i++) begin
      assert (got_q[i] == base_q[i]) else begin
        mismatches++;
        $display("MISMATCH at %0t: result %0d is %0d with gaps, %0d without",
                 $time, i, got_q[i], base_q[i]);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      assert (res.valid !== 1'b1) else begin
        other_errors++;
        $display("result valid raised during reset at %0t", $time);
      end
    end else if (res.valid === 1'b1) begin
      res_count++;
      got_q.push_back(res.median);
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("result %0d at %0t arrived with none expected", res.median, $time);
      end
      if (exp_q.size() != 0) begin
        exp_val = exp_q.pop_front();
        assert (res.median == exp_val) else begin
          mismatches++;
          $display("MISMATCH at %0t: expected %0d, got %0d", $time, exp_val, res.median);
        end
      end
    end
  end

  initial begin
    seed = 84;
    rst  = 1'b1;
    pix  = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    fill_random();
    run_frame(1'b0);
    base_q = got_q;
    run_frame(1'b1);  // same frame again, now with idle gaps.
    compare_runs();
    run_start = res_count;
    for (int f = 0; f < 3; f++) begin
      fill_random();
      push_expected();
      send_frame(1'b1);
    end
    wait_drain();
    check_count(3 * PER_FRAME);
    fill_constant(8'd0);
    run_frame(1'b1);
    fill_constant(8'd255);
    run_frame(1'b0);
    fill_checkerboard();
    run_frame(1'b1);
    $display("error count: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
source/median_pkg.sv
source/sort3.sv
source/median_calc.sv
source/line_buffer.sv
source/window_gen.sv
source/median_filter_top.sv
verification/median_filter_assertions.sv
verification/median_filter_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := median_filter_tb
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
PASS     := NO ERRORS

SOURCES  := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS)$$" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
